// ==== src/rv32i_pkg.sv ====
/*
 * RV32I widths and opcodes, ALU operations, instruction format views
 * and the control word carried through the ID/EX register
 */
package rv32i_pkg;

    localparam int xlen       = 32;
    localparam int reg_addr_w = 5;

    localparam logic [6:0] op_op     = 7'b0110011;
    localparam logic [6:0] op_imm    = 7'b0010011;
    localparam logic [6:0] op_lui    = 7'b0110111;
    localparam logic [6:0] op_auipc  = 7'b0010111;
    localparam logic [6:0] op_jal    = 7'b1101111;
    localparam logic [6:0] op_jalr   = 7'b1100111;
    localparam logic [6:0] op_branch = 7'b1100011;

    typedef enum logic [3:0] {
        alu_add, alu_sub, alu_sll, alu_slt, alu_sltu, alu_xor,
        alu_srl, alu_sra, alu_or, alu_and, alu_pass_b
    } alu_op_t;

    typedef enum logic [1:0] {imm_i, imm_u, imm_j, imm_b} imm_sel_t;

    typedef struct packed {
        logic [6:0] funct7;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] rd;
        logic [6:0] opcode;
    } r_type_t;

    typedef struct packed {
        logic [11:0] imm;
        logic [4:0]  rs1;
        logic [2:0]  funct3;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } i_type_t;

    typedef struct packed {
        logic [6:0] imm_11_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [4:0] imm_4_0;
        logic [6:0] opcode;
    } s_type_t;

    typedef struct packed {
        logic       imm_12;
        logic [5:0] imm_10_5;
        logic [4:0] rs2;
        logic [4:0] rs1;
        logic [2:0] funct3;
        logic [3:0] imm_4_1;
        logic       imm_11;
        logic [6:0] opcode;
    } b_type_t;

    typedef struct packed {
        logic [19:0] imm;
        logic [4:0]  rd;
        logic [6:0]  opcode;
    } u_type_t;

    typedef struct packed {
        logic       imm_20;
        logic [9:0] imm_10_1;
        logic       imm_11;
        logic [7:0] imm_19_12;
        logic [4:0] rd;
        logic [6:0] opcode;
    } j_type_t;

    // One instruction word seen through every base format
    typedef union packed {
        r_type_t r;
        i_type_t i;
        s_type_t s;
        b_type_t b;
        u_type_t u;
        j_type_t j;
    } instr_u;

    typedef struct packed {
        logic     valid;
        logic     reg_write;
        alu_op_t  alu_op;
        logic     alu_src_imm;    // Operand b is the selected immediate
        imm_sel_t imm_sel;
        logic     is_branch;
        logic     is_jal;
        logic     is_jalr;
        logic     is_auipc;
    } control_word_t;

endpackage

// ==== src/pipeline_registers_if.sv ====
/*
 * ID/EX signal bundle with decode, register and execute views
 */
`timescale 1ns/1ps

interface pipeline_registers_if import rv32i_pkg::*; ();

    logic [xlen-1:0]       pc, pc_in;
    logic [xlen-1:0]       next_pc, next_pc_in;
    logic [xlen-1:0]       i_imm, i_imm_in;
    logic [xlen-1:0]       b_imm, b_imm_in;
    logic [xlen-1:0]       u_imm, u_imm_in;
    logic [xlen-1:0]       j_imm, j_imm_in;
    logic [reg_addr_w-1:0] rs1, rs1_in;
    logic [reg_addr_w-1:0] rs2, rs2_in;
    logic [reg_addr_w-1:0] rd, rd_in;
    logic [2:0]            funct3, funct3_in;
    logic [6:0]            funct7, funct7_in;
    control_word_t         control_word, control_word_in;
    logic [xlen-1:0]       rs1_out, rs1_out_in;
    logic [xlen-1:0]       rs2_out, rs2_out_in;
    logic                  en;
    logic                  flush;

    modport decode (
        output pc_in, next_pc_in, i_imm_in, b_imm_in, u_imm_in, j_imm_in,
               rs1_in, rs2_in, rd_in, funct3_in, funct7_in, control_word_in,
               rs1_out_in, rs2_out_in
    );

    modport idex (
        input  pc_in, next_pc_in, i_imm_in, b_imm_in, u_imm_in, j_imm_in,
               rs1_in, rs2_in, rd_in, funct3_in, funct7_in, control_word_in,
               rs1_out_in, rs2_out_in, en, flush,
        output pc, next_pc, i_imm, b_imm, u_imm, j_imm,
               rs1, rs2, rd, funct3, funct7, control_word, rs1_out, rs2_out
    );

    modport execute (
        input  pc, next_pc, i_imm, b_imm, u_imm, j_imm,
               rs1, rs2, rd, funct3, funct7, control_word, rs1_out, rs2_out,
        output flush
    );

endinterface

// ==== src/reg_file.sv ====
/*
 * Integer register file, two read ports, one write port, write-first reads
 */
`timescale 1ns/1ps

module reg_file import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic [reg_addr_w-1:0] ra1,
    input  logic [reg_addr_w-1:0] ra2,
    output logic [xlen-1:0]       rd1,
    output logic [xlen-1:0]       rd2,
    input  logic                  we,
    input  logic [reg_addr_w-1:0] wa,
    input  logic [xlen-1:0]       wd
);

    logic [xlen-1:0] regs [1:31];    // x0 has no storage

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            for (int k = 1; k < 32; k++) begin
                regs[k] <= '0;
            end
        end else if (we && wa != '0) begin
            regs[wa] <= wd;
        end
    end

    // A write in the same cycle wins over the stored value
    assign rd1 = (ra1 == '0) ? '0 : (we && wa == ra1) ? wd : regs[ra1];
    assign rd2 = (ra2 == '0) ? '0 : (we && wa == ra2) ? wd : regs[ra2];

endmodule

// ==== src/decode_stage.sv ====
/*
 * Instruction decode: control word, immediates and register operand read
 */
`timescale 1ns/1ps

module decode_stage import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  instr_u                id_instr,
    input  logic [xlen-1:0]       id_pc,
    input  logic [xlen-1:0]       id_next_pc,
    input  logic                  wb_en,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    pipeline_registers_if.decode  pif
);

    logic [6:0]    opcode;
    logic          shift_op;
    alu_op_t       base_op;
    control_word_t cw;

    assign opcode   = id_instr.r.opcode;
    assign shift_op = (id_instr.r.funct3[1:0] == 2'b01);

    reg_file reg_file_inst (
        .clk (clk),
        .rst (rst),
        .ra1 (id_instr.r.rs1),
        .ra2 (id_instr.r.rs2),
        .rd1 (pif.rs1_out_in),
        .rd2 (pif.rs2_out_in),
        .we  (wb_en),
        .wa  (wb_rd),
        .wd  (wb_data)
    );

    // funct7 refines add and srl later in execute
    always_comb begin
        case (id_instr.r.funct3)
            3'b000:  base_op = alu_add;
            3'b001:  base_op = alu_sll;
            3'b010:  base_op = alu_slt;
            3'b011:  base_op = alu_sltu;
            3'b100:  base_op = alu_xor;
            3'b101:  base_op = alu_srl;
            3'b110:  base_op = alu_or;
            default: base_op = alu_and;
        endcase
    end

    always_comb begin
        cw = '0;
        cw.valid = 1'b1;
        cw.reg_write = 1'b1;
        case (opcode)
            op_op: begin
                cw.alu_op = base_op;
            end
            op_imm: begin
                cw.alu_op = base_op;
                cw.alu_src_imm = 1'b1;
            end
            op_lui: begin
                cw.alu_op = alu_pass_b;
                cw.alu_src_imm = 1'b1;
                cw.imm_sel = imm_u;
            end
            op_auipc: begin
                cw.alu_src_imm = 1'b1;
                cw.imm_sel = imm_u;
                cw.is_auipc = 1'b1;
            end
            op_jal: begin
                cw.imm_sel = imm_j;
                cw.is_jal = 1'b1;
            end
            op_jalr: begin
                cw.alu_src_imm = 1'b1;    // ALU forms the jump target rs1 + imm
                cw.is_jalr = 1'b1;
            end
            op_branch: begin
                cw.reg_write = 1'b0;
                cw.imm_sel = imm_b;
                cw.is_branch = 1'b1;
            end
            default: cw = '0;
        endcase
        if (!id_valid) begin
            cw = '0;
        end
    end

    assign pif.control_word_in = cw;
    assign pif.pc_in           = id_pc;
    assign pif.next_pc_in      = id_next_pc;
    assign pif.rs1_in          = id_instr.r.rs1;
    assign pif.rs2_in          = id_instr.r.rs2;
    assign pif.rd_in           = id_instr.r.rd;
    assign pif.funct3_in       = id_instr.r.funct3;

    // Only R-type words and immediate shifts carry a real funct7
    assign pif.funct7_in = (opcode == op_op || (opcode == op_imm && shift_op)) ?
                           id_instr.r.funct7 : '0;

    assign pif.i_imm_in = {{20{id_instr.i.imm[11]}}, id_instr.i.imm};
    assign pif.b_imm_in = {{19{id_instr.b.imm_12}}, id_instr.b.imm_12, id_instr.b.imm_11,
                           id_instr.b.imm_10_5, id_instr.b.imm_4_1, 1'b0};
    assign pif.u_imm_in = {id_instr.u.imm, 12'b0};
    assign pif.j_imm_in = {{11{id_instr.j.imm_20}}, id_instr.j.imm_20, id_instr.j.imm_19_12,
                           id_instr.j.imm_11, id_instr.j.imm_10_1, 1'b0};

endmodule

// ==== src/idex_reg.sv ====
/*
 * ID/EX pipeline register: load on enable, bubble on flush, hold otherwise
 */
`timescale 1ns/1ps

module idex_reg (
    input logic                clk,
    input logic                rst,
    pipeline_registers_if.idex pif
);

    always_ff @(posedge clk, posedge rst) begin
        if (rst) begin
            pif.pc           <= '0;
            pif.next_pc      <= '0;
            pif.i_imm        <= '0;
            pif.b_imm        <= '0;
            pif.u_imm        <= '0;
            pif.j_imm        <= '0;
            pif.rs1          <= '0;
            pif.rs2          <= '0;
            pif.rd           <= '0;
            pif.funct3       <= '0;
            pif.funct7       <= '0;
            pif.control_word <= '0;
            pif.rs1_out      <= '0;
            pif.rs2_out      <= '0;
        end else if (pif.en) begin
            // A flush replaces the incoming instruction with a bubble
            pif.pc           <= pif.flush ? '0 : pif.pc_in;
            pif.next_pc      <= pif.flush ? '0 : pif.next_pc_in;
            pif.i_imm        <= pif.flush ? '0 : pif.i_imm_in;
            pif.b_imm        <= pif.flush ? '0 : pif.b_imm_in;
            pif.u_imm        <= pif.flush ? '0 : pif.u_imm_in;
            pif.j_imm        <= pif.flush ? '0 : pif.j_imm_in;
            pif.rs1          <= pif.flush ? '0 : pif.rs1_in;
            pif.rs2          <= pif.flush ? '0 : pif.rs2_in;
            pif.rd           <= pif.flush ? '0 : pif.rd_in;
            pif.funct3       <= pif.flush ? '0 : pif.funct3_in;
            pif.funct7       <= pif.flush ? '0 : pif.funct7_in;
            pif.control_word <= pif.flush ? '0 : pif.control_word_in;
            pif.rs1_out      <= pif.flush ? '0 : pif.rs1_out_in;
            pif.rs2_out      <= pif.flush ? '0 : pif.rs2_out_in;
        end
    end

endmodule

// ==== src/execute_stage.sv ====
/*
 * Execute stage with ALU, branch resolution and next pc check with redirect
 */
`timescale 1ns/1ps

module execute_stage import rv32i_pkg::*; (
    pipeline_registers_if.execute pif,
    output logic                  ex_valid,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic [xlen-1:0]       ex_result,
    output logic                  ex_reg_write,
    output logic                  redirect,
    output logic [xlen-1:0]       redirect_pc
);

    control_word_t   cw;
    alu_op_t         op;
    logic            taken;
    logic [xlen-1:0] imm;
    logic [xlen-1:0] op_a;
    logic [xlen-1:0] op_b;
    logic [xlen-1:0] alu_result;
    logic [xlen-1:0] pc_plus4;
    logic [xlen-1:0] jump_target;
    logic [xlen-1:0] real_next_pc;

    assign cw       = pif.control_word;
    assign pc_plus4 = pif.pc + xlen'(4);

    always_comb begin
        case (cw.imm_sel)
            imm_u:   imm = pif.u_imm;
            imm_j:   imm = pif.j_imm;
            imm_b:   imm = pif.b_imm;
            default: imm = pif.i_imm;
        endcase
    end

    assign op_a = cw.is_auipc ? pif.pc : pif.rs1_out;
    assign op_b = cw.alu_src_imm ? imm : pif.rs2_out;

    always_comb begin
        op = cw.alu_op;
        if (pif.funct7[5] && cw.alu_op == alu_add) begin
            op = alu_sub;
        end else if (pif.funct7[5] && cw.alu_op == alu_srl) begin
            op = alu_sra;
        end
    end

    always_comb begin
        case (op)
            alu_sub:    alu_result = op_a - op_b;
            alu_sll:    alu_result = op_a << op_b[4:0];
            alu_slt:    alu_result = {{(xlen-1){1'b0}}, $signed(op_a) < $signed(op_b)};
            alu_sltu:   alu_result = {{(xlen-1){1'b0}}, op_a < op_b};
            alu_xor:    alu_result = op_a ^ op_b;
            alu_srl:    alu_result = op_a >> op_b[4:0];
            alu_sra:    alu_result = $unsigned($signed(op_a) >>> op_b[4:0]);
            alu_or:     alu_result = op_a | op_b;
            alu_and:    alu_result = op_a & op_b;
            alu_pass_b: alu_result = op_b;
            default:    alu_result = op_a + op_b;
        endcase
    end

    always_comb begin
        case (pif.funct3)
            3'b000:  taken = (pif.rs1_out == pif.rs2_out);
            3'b001:  taken = (pif.rs1_out != pif.rs2_out);
            3'b100:  taken = ($signed(pif.rs1_out) < $signed(pif.rs2_out));
            3'b101:  taken = ($signed(pif.rs1_out) >= $signed(pif.rs2_out));
            3'b110:  taken = (pif.rs1_out < pif.rs2_out);
            3'b111:  taken = (pif.rs1_out >= pif.rs2_out);
            default: taken = 1'b0;
        endcase
    end

    assign jump_target = pif.pc + imm;    // imm_sel picks the J or B offset

    always_comb begin
        if (cw.is_jalr) begin
            real_next_pc = {alu_result[xlen-1:1], 1'b0};
        end else if (cw.is_jal || (cw.is_branch && taken)) begin
            real_next_pc = jump_target;
        end else begin
            real_next_pc = pc_plus4;
        end
    end

    assign redirect     = cw.valid && (real_next_pc != pif.next_pc);
    assign redirect_pc  = real_next_pc;
    assign pif.flush    = redirect;    // Kills the instruction now in decode
    assign ex_valid     = cw.valid;
    assign ex_reg_write = cw.reg_write;
    assign ex_rd        = pif.rd;
    assign ex_result    = (cw.is_jal || cw.is_jalr) ? pc_plus4 : alu_result;

endmodule

// ==== src/id_ex_core.sv ====
/*
 * Decode to execute slice of an RV32I pipeline around the ID/EX register
 */
`timescale 1ns/1ps

module id_ex_core import rv32i_pkg::*; (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  id_valid,
    input  logic [xlen-1:0]       id_instr,
    input  logic [xlen-1:0]       id_pc,
    input  logic [xlen-1:0]       id_next_pc,
    input  logic                  advance,
    input  logic                  wb_en,
    input  logic [reg_addr_w-1:0] wb_rd,
    input  logic [xlen-1:0]       wb_data,
    output logic                  ex_valid,
    output logic [reg_addr_w-1:0] ex_rd,
    output logic [xlen-1:0]       ex_result,
    output logic                  ex_reg_write,
    output logic                  redirect,
    output logic [xlen-1:0]       redirect_pc
);

    pipeline_registers_if pif ();

    assign pif.en = advance;

    decode_stage decode_stage_inst (
        .clk        (clk),
        .rst        (rst),
        .id_valid   (id_valid),
        .id_instr   (id_instr),
        .id_pc      (id_pc),
        .id_next_pc (id_next_pc),
        .wb_en      (wb_en),
        .wb_rd      (wb_rd),
        .wb_data    (wb_data),
        .pif        (pif.decode)
    );

    idex_reg idex_reg_inst (
        .clk (clk),
        .rst (rst),
        .pif (pif.idex)
    );

    execute_stage execute_stage_inst (
        .pif          (pif.execute),
        .ex_valid     (ex_valid),
        .ex_rd        (ex_rd),
        .ex_result    (ex_result),
        .ex_reg_write (ex_reg_write),
        .redirect     (redirect),
        .redirect_pc  (redirect_pc)
    );

endmodule

// ==== verif/tb_id_ex_core.sv ====
/*
 * Testbench for the ID/EX slice with random RV32I stream, reference model,
 * retirement checker and watchdog
 */
`timescale 1ns/1ps

module tb_id_ex_core;

    localparam int num_instr    = 400;
    localparam int clk_period   = 4;
    localparam int reset_cycles = 3;

    typedef struct packed {
        logic        valid;
        logic        reg_write;
        logic        redirect;
        logic [4:0]  rd;
        logic [31:0] result;
        logic [31:0] next_pc;
    } expect_t;

    logic        clk;
    logic        rst;
    logic        id_valid;
    logic [31:0] id_instr;
    logic [31:0] id_pc;
    logic [31:0] id_next_pc;
    logic        advance;
    logic        wb_en;
    logic [4:0]  wb_rd;
    logic [31:0] wb_data;
    logic        ex_valid;
    logic [4:0]  ex_rd;
    logic [31:0] ex_result;
    logic        ex_reg_write;
    logic        redirect;
    logic [31:0] redirect_pc;

    logic [31:0] rng_state = 32'd15282;
    logic [31:0] shadow [0:31];
    expect_t     expected_q [$];
    expect_t     e;
    expect_t     head;
    logic [31:0] ins, r, r2, pc_v, pred_v, wb_data_v;
    logic [4:0]  rs1_v, rs2_v, rd_v, wb_rd_v;
    logic [2:0]  f3_v;
    logic        valid_v, wb_en_v, kill_next, kill_pending;
    int          cls, gap;
    int          errors = 0;
    int          checks = 0;

    id_ex_core id_ex_core_inst (.*);

    initial clk = 1'b0;
    always #(clk_period / 2) clk = ~clk;

    function automatic logic [31:0] xorshift32();
        logic [31:0] x;
        x = rng_state;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        rng_state = x;
        return x;
    endfunction

    // Expected outcome of one instruction from the RV32I rules
    function automatic expect_t reference(input logic [31:0] w, input logic [31:0] pc,
                                          input logic [31:0] a, input logic [31:0] b);
        expect_t     x;
        logic [31:0] imm_i, imm_u, imm_b, imm_j, src2;
        logic        alt, taken;
        x = '0;
        imm_i = {{20{w[31]}}, w[31:20]};
        imm_u = {w[31:12], 12'b0};
        imm_b = {{20{w[31]}}, w[7], w[30:25], w[11:8], 1'b0};
        imm_j = {{12{w[31]}}, w[19:12], w[20], w[30:21], 1'b0};
        x.valid = 1'b1;
        x.reg_write = 1'b1;
        x.rd = w[11:7];
        x.next_pc = pc + 32'd4;
        case (w[6:0])
            7'b0110011, 7'b0010011: begin
                src2 = w[5] ? b : imm_i;    // Opcode bit 5 separates OP from OP-IMM
                alt = w[30] && (w[5] || w[14:12] == 3'b101);
                case (w[14:12])
                    3'b000:  x.result = alt ? a - src2 : a + src2;
                    3'b001:  x.result = a << src2[4:0];
                    3'b010:  x.result = {31'b0, $signed(a) < $signed(src2)};
                    3'b011:  x.result = {31'b0, a < src2};
                    3'b100:  x.result = a ^ src2;
                    3'b101:  x.result = alt ? $unsigned($signed(a) >>> src2[4:0])
                                            : a >> src2[4:0];
                    3'b110:  x.result = a | src2;
                    default: x.result = a & src2;
                endcase
            end
            7'b0110111: x.result = imm_u;
            7'b0010111: x.result = pc + imm_u;
            7'b1101111: begin
                x.result = pc + 32'd4;
                x.next_pc = pc + imm_j;
            end
            7'b1100111: begin
                x.result = pc + 32'd4;
                x.next_pc = (a + imm_i) & ~32'h1;
            end
            7'b1100011: begin
                x.reg_write = 1'b0;
                case (w[14:12])
                    3'b000:  taken = (a == b);
                    3'b001:  taken = (a != b);
                    3'b100:  taken = ($signed(a) < $signed(b));
                    3'b101:  taken = ($signed(a) >= $signed(b));
                    3'b110:  taken = (a < b);
                    default: taken = (a >= b);
                endcase
                if (taken) begin
                    x.next_pc = pc + imm_b;
                end
            end
            default: x = '0;
        endcase
        return x;
    endfunction

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("error: time %0t %s expected %h actual %h", $time, name, expected, actual);
        end
    endtask

    task automatic drive_cycle(input logic adv);
        @(posedge clk);
        id_valid   <= valid_v;
        id_instr   <= ins;
        id_pc      <= pc_v;
        id_next_pc <= pred_v;
        advance    <= adv;
        wb_en      <= adv & wb_en_v;    // Write only on the latching cycle
        wb_rd      <= wb_rd_v;
        wb_data    <= wb_data_v;
    endtask

    initial begin
        rst = 1'b1;
        id_valid = 1'b0;
        id_instr = '0;
        id_pc = '0;
        id_next_pc = '0;
        advance = 1'b0;
        wb_en = 1'b0;
        wb_rd = '0;
        wb_data = '0;
        kill_next = 1'b0;
        for (int k = 0; k < 32; k++) begin
            shadow[k] = '0;
        end
        repeat (reset_cycles) @(posedge clk);
        rst <= 1'b0;
        for (int n = 0; n < num_instr; n++) begin
            r = xorshift32();
            r2 = xorshift32();
            wb_data_v = xorshift32();
            pc_v = xorshift32() & ~32'h3;
            rs1_v = {2'b0, r2[2:0]};
            rs2_v = {2'b0, r2[5:3]};
            rd_v = r2[10:6];
            f3_v = r2[13:11];
            cls = r2[19:14] % 10;
            wb_en_v = (r2[21:20] == 2'b00);
            wb_rd_v = {2'b0, r2[24:22]};
            gap = (r2[27:26] == 2'b00) ? r2[29:28] + 1 : 0;
            valid_v = !(cls == 9 && r[1]);
            case (cls)
                0, 1: begin
                    ins = {(f3_v == 3'b000 || f3_v == 3'b101) ? {1'b0, r[30], 5'b0} : 7'b0,
                           rs2_v, rs1_v, f3_v, rd_v, 7'b0110011};
                end
                2, 3: begin
                    ins = {r[31:20], rs1_v, f3_v, rd_v, 7'b0010011};
                    if (f3_v[1:0] == 2'b01) begin
                        ins[31:25] = {1'b0, r[30] & f3_v[2], 5'b0};    // Legal shift forms
                    end
                end
                4: ins = {r[31:12], rd_v, 7'b0110111};
                5: ins = {r[31:12], rd_v, 7'b0010111};
                6: ins = {r[31:12], rd_v, 7'b1101111};
                7: ins = {r[31:20], rs1_v, 3'b000, rd_v, 7'b1100111};
                8: ins = {r[31:25], rs2_v, rs1_v,
                          (f3_v[2:1] == 2'b01) ? (f3_v ^ 3'b110) : f3_v, r[11:7], 7'b1100011};
                default: ins = {r[31:7], r[1] ? 7'b0110011 : 7'b0000011};
            endcase
            // The write lands in the same cycle as the operand read
            if (wb_en_v && wb_rd_v != 5'd0) begin
                shadow[wb_rd_v] = wb_data_v;
            end
            e = reference(ins, pc_v, shadow[ins[19:15]], shadow[ins[24:20]]);
            if (!valid_v) begin
                e = '0;
            end
            case (r2[31:30])
                2'b10:   pred_v = pc_v + 32'd4;
                2'b11:   pred_v = e.next_pc ^ 32'h100;
                default: pred_v = e.next_pc;
            endcase
            e.redirect = e.valid && (e.next_pc != pred_v);
            repeat (gap) drive_cycle(1'b0);
            drive_cycle(1'b1);
            if (!kill_next && e.valid) begin
                expected_q.push_back(e);
            end
            kill_next = kill_next ? 1'b0 : e.redirect;    // A killed slot is a bubble
        end
        valid_v = 1'b0;
        repeat (2) drive_cycle(1'b1);
        drive_cycle(1'b0);
        @(posedge clk);
        if (expected_q.size() != 0) begin
            errors++;
            $display("error: time %0t %0d issued instructions never retired",
                     $time, expected_q.size());
        end
        $display("checks %0d errors %0d", checks, errors);
        if (errors == 0) begin
            $display("RESULT: PASS");
        end else begin
            $display("RESULT: FAIL");
        end
        $finish;
    end

    // Outputs are settled at the falling edge, one half cycle before any latch
    initial kill_pending = 1'b0;
    always @(negedge clk) begin
        if (kill_pending) begin
            check_value("ex_valid", ex_valid, 32'd0);
            if (advance) begin
                kill_pending = 1'b0;
            end
        end
        if (!ex_valid) begin
            check_value("ex_reg_write", ex_reg_write, 32'd0);
            check_value("redirect", redirect, 32'd0);
        end else if (expected_q.size() == 0) begin
            errors++;
            $display("error: time %0t a result is valid with no instruction issued", $time);
        end else begin
            head = expected_q[0];
            check_value("ex_reg_write", ex_reg_write, head.reg_write);
            if (head.reg_write) begin
                check_value("ex_rd", ex_rd, head.rd);
                check_value("ex_result", ex_result, head.result);
            end
            check_value("redirect", redirect, head.redirect);
            check_value("redirect_pc", redirect_pc, head.next_pc);
            if (advance) begin
                void'(expected_q.pop_front());
                kill_pending = head.redirect;
            end
        end
    end

    initial begin
        #((num_instr * 8 + reset_cycles) * clk_period);
        $display("watchdog timeout: the instruction stream did not finish in time");
        $display("RESULT: FAIL");
        $finish;
    end

endmodule

// ==== compile.f ====
src/rv32i_pkg.sv
src/pipeline_registers_if.sv
src/reg_file.sv
src/decode_stage.sv
src/idex_reg.sv
src/execute_stage.sv
src/id_ex_core.sv
verif/tb_id_ex_core.sv

// ==== Bender.yml ====
package:
  name: id_ex_core

sources:
  - files:
      - src/rv32i_pkg.sv
      - src/pipeline_registers_if.sv
      - src/reg_file.sv
      - src/decode_stage.sv
      - src/idex_reg.sv
      - src/execute_stage.sv
      - src/id_ex_core.sv
  - target: test
    files:
      - verif/tb_id_ex_core.sv
